// File: thorDecodePkg.sv
// Thor decode stage shared definitions
// Widths, opcode and function encodings, instruction field positions
// and small helpers used by every block of the decode stage

`default_nettype none

package thorDecodePkg;

	// ==============================
	// Widths
	// ==============================
	localparam int instrWidth  = 40;
	localparam int valueWidth  = 64;
	localparam int regWidth    = 5;
	localparam int pfxWidth    = 33;
	localparam int immLowWidth = 24;

	typedef logic [instrWidth-1:0] instrT;
	typedef logic [valueWidth-1:0] valueT;
	typedef logic [regWidth-1:0]   regT;

	// ==============================
	// Instruction field positions
	// ==============================
	localparam int opcodeLo = 0;
	localparam int opcodeHi = 6;
	localparam int rtLo     = 7;
	localparam int rtHi     = 11;
	// Link field shares the low bits of rt on jumps
	localparam int lkLo     = 7;
	localparam int lkHi     = 8;
	localparam int raLo     = 12;
	localparam int raHi     = 16;
	localparam int rbLo     = 17;
	localparam int rbHi     = 21;
	localparam int rcLo     = 22;
	localparam int rcHi     = 26;
	localparam int funcLo   = 27;
	localparam int funcHi   = 33;
	localparam int imm13Lo  = 17;
	localparam int imm13Hi  = 29;
	localparam int shamtLo  = 17;
	localparam int shamtHi  = 22;
	localparam int disp23Lo = 17;
	localparam int disp23Hi = 39;
	localparam int jmpTgtLo = 12;
	localparam int jmpTgtHi = 39;
	localparam int braTgtLo = 27;
	localparam int braTgtHi = 39;
	localparam int pfxLo    = 7;
	localparam int pfxHi    = 39;

	// ==============================
	// Encodings
	// ==============================
	typedef enum logic [6:0] {
		NOP  = 7'h00, R2   = 7'h02, ADDI = 7'h04, ANDI = 7'h08,
		ORI  = 7'h09, XORI = 7'h0A, SLLI = 7'h0C,
		JMP  = 7'h20, BRA  = 7'h21, JEQ  = 7'h26, JNE  = 7'h27, JLT = 7'h28,
		LDB  = 7'h40, LDBU = 7'h41, LDW  = 7'h42, LDWU = 7'h43, LDO = 7'h46,
		LDBX = 7'h48, LDOX = 7'h4E,
		STB  = 7'h50, STW  = 7'h52, STO  = 7'h56, STBX = 7'h58, STOX = 7'h5E,
		EXI  = 7'h7C
	} opcodeT;

	// Function field of R2 operations
	typedef enum logic [6:0] {
		ADD = 7'h04, SUB = 7'h05, AND = 7'h08, OR = 7'h09,
		MUL = 7'h0C, DIV = 7'h0D, SLL = 7'h10
	} funcT;

	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd3
	} memSzT;

	// ==============================
	// Helpers
	// ==============================
	function automatic opcodeT opcodeOf(input instrT ir);
		return opcodeT'(ir[opcodeHi:opcodeLo]);
	endfunction

	function automatic funcT funcOf(input instrT ir);
		return funcT'(ir[funcHi:funcLo]);
	endfunction

	function automatic logic isLoadOp(input opcodeT op);
		return op inside {LDB, LDBU, LDW, LDWU, LDO, LDBX, LDOX};
	endfunction

	function automatic logic isStoreOp(input opcodeT op);
		return op inside {STB, STW, STO, STBX, STOX};
	endfunction

	// Unconditional jumps and conditional branches alike
	function automatic logic isFlowOp(input opcodeT op);
		return op inside {JMP, BRA, JEQ, JNE, JLT};
	endfunction

endpackage

`default_nettype wire

// File: thorDecodeCtrl.sv
// Thor decode control
// Captures EXI prefixes, issues the decode strobe to the datapath
// blocks and produces the output valid pulse one cycle later

`timescale 1ns/1ps
`default_nettype none

module thorDecodeCtrl (
	input  wire                                  clk,
	input  wire                                  rstN,
	input  wire                                  irValid,
	input  thorDecodePkg::instrT                 ir,
	output logic                                 decEn,
	output logic                                 pfxValid,
	output logic [thorDecodePkg::pfxWidth-1:0]   pfxExt,
	output logic                                 decoValid
);

	import thorDecodePkg::*;

	logic isExi;
	logic pfxLoad;

	// ==============================
	// Strobes
	// ==============================

	// A prefix is never decoded as an instruction
	assign isExi   = (opcodeOf(ir) == EXI);
	assign pfxLoad = irValid && isExi;
	assign decEn   = irValid && !isExi;

	// ==============================
	// Prefix and valid registers
	// ==============================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pfxValid  <= 1'b0;
			pfxExt    <= '0;
			decoValid <= 1'b0;
		end
		else
		begin
			decoValid <= decEn;
			// New prefix wins; otherwise the decoded instruction consumes it
			if (pfxLoad)
			begin
				pfxValid <= 1'b1;
				pfxExt   <= ir[pfxHi:pfxLo];
			end
			else if (decEn)
				pfxValid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: thorRegSelect.sv
// Thor register-field selection
// Picks Ra, Rb, Rc and Rt from the instruction and flags register
// file writes, registered on the decode strobe

`timescale 1ns/1ps
`default_nettype none

module thorRegSelect (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   decEn,
	input  thorDecodePkg::instrT  ir,
	output thorDecodePkg::regT    ra,
	output thorDecodePkg::regT    rb,
	output thorDecodePkg::regT    rc,
	output thorDecodePkg::regT    rt,
	output logic                  rfwr
);

	import thorDecodePkg::*;

	opcodeT op;
	logic [lkHi-lkLo:0] lk;
	regT rcNext;
	regT rtNext;
	logic rfwrNext;

	assign op = opcodeOf(ir);
	assign lk = ir[lkHi:lkLo];

	always_comb
	begin
		// Stores carry the data register in the rt slot
		rcNext = isStoreOp(op) ? regT'(ir[rtHi:rtLo]) : regT'(ir[rcHi:rcLo]);

		if (isStoreOp(op) || op == NOP)
			rtNext = '0;
		else if (isFlowOp(op))
			rtNext = regT'(lk);
		else
			rtNext = ir[rtHi:rtLo];

		if (op inside {R2, ADDI, ANDI, ORI, XORI, SLLI} || isLoadOp(op))
			rfwrNext = 1'b1;
		else if (isFlowOp(op))
			rfwrNext = (lk != '0);	// link write only
		else
			rfwrNext = 1'b0;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ra   <= '0;
			rb   <= '0;
			rc   <= '0;
			rt   <= '0;
			rfwr <= 1'b0;
		end
		else if (decEn)
		begin
			ra   <= ir[raHi:raLo];
			rb   <= ir[rbHi:rbLo];
			rc   <= rcNext;
			rt   <= rtNext;
			rfwr <= rfwrNext;
		end
	end

endmodule

`default_nettype wire

// File: thorConstGen.sv
// Thor constant generator
// Builds the immediate and the branch target of each instruction,
// widening the immediate with a pending EXI prefix

`timescale 1ns/1ps
`default_nettype none

module thorConstGen (
	input  wire                                  clk,
	input  wire                                  rstN,
	input  wire                                  decEn,
	input  thorDecodePkg::instrT                 ir,
	input  wire                                  pfxValid,
	input  wire [thorDecodePkg::pfxWidth-1:0]    pfxExt,
	output thorDecodePkg::valueT                 imm,
	output thorDecodePkg::valueT                 jmpTgt
);

	import thorDecodePkg::*;

	localparam int imm13W  = imm13Hi - imm13Lo + 1;
	localparam int shamtW  = shamtHi - shamtLo + 1;
	localparam int disp23W = disp23Hi - disp23Lo + 1;
	localparam int jmpW    = jmpTgtHi - jmpTgtLo + 1;
	localparam int braW    = braTgtHi - braTgtLo + 1;

	opcodeT op;
	logic [imm13W-1:0] imm13;
	logic [shamtW-1:0] shamt;
	logic [disp23W-1:0] disp23;
	logic [jmpW-1:0] jmpField;
	logic [braW-1:0] braField;
	valueT immPlain;
	valueT immNext;
	valueT tgtNext;

	assign op       = opcodeOf(ir);
	assign imm13    = ir[imm13Hi:imm13Lo];
	assign shamt    = ir[shamtHi:shamtLo];
	assign disp23   = ir[disp23Hi:disp23Lo];
	assign jmpField = ir[jmpTgtHi:jmpTgtLo];
	assign braField = ir[braTgtHi:braTgtLo];

	always_comb
	begin
		case (op)
		ADDI:       immPlain = {{(valueWidth-imm13W){imm13[imm13W-1]}}, imm13};
		ANDI:       immPlain = {{(valueWidth-imm13W){1'b1}}, imm13};
		ORI, XORI:  immPlain = {{(valueWidth-imm13W){1'b0}}, imm13};
		SLLI:       immPlain = {{(valueWidth-shamtW){1'b0}}, shamt};
		// Indexed forms take their offset from Rb instead
		LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO:
			immPlain = {{(valueWidth-disp23W){disp23[disp23W-1]}}, disp23};
		default:    immPlain = '0;
		endcase

		// Prefix sits above the low part and sets the sign
		if (pfxValid)
			immNext = {{(valueWidth-pfxWidth-immLowWidth){pfxExt[pfxWidth-1]}},
				pfxExt, immPlain[immLowWidth-1:0]};
		else
			immNext = immPlain;

		case (op)
		JMP, BRA:       tgtNext = {{(valueWidth-jmpW-1){jmpField[jmpW-1]}}, jmpField, 1'b0};
		JEQ, JNE, JLT:  tgtNext = {{(valueWidth-braW-1){braField[braW-1]}}, braField, 1'b0};
		default:        tgtNext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			imm    <= '0;
			jmpTgt <= '0;
		end
		else if (decEn)
		begin
			imm    <= immNext;
			jmpTgt <= tgtNext;
		end
	end

endmodule

`default_nettype wire

// File: thorOpClass.sv
// Thor operation classifier
// Memory, flow and latency flags for the issue logic, registered
// on the decode strobe

`timescale 1ns/1ps
`default_nettype none

module thorOpClass (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   decEn,
	input  thorDecodePkg::instrT  ir,
	output logic                  isLoad,
	output logic                  isStore,
	output logic                  ldz,
	output logic                  isIndexed,
	output thorDecodePkg::memSzT  memSz,
	output logic                  isJump,
	output logic                  isCbranch,
	output logic                  isMul,
	output logic                  isDiv,
	output logic                  multiCycle
);

	import thorDecodePkg::*;

	opcodeT op;
	logic ld;
	logic st;
	logic mul;
	logic div;
	memSzT szNext;

	assign op  = opcodeOf(ir);
	assign ld  = isLoadOp(op);
	assign st  = isStoreOp(op);
	assign mul = (op == R2) && (funcOf(ir) == MUL);
	assign div = (op == R2) && (funcOf(ir) == DIV);

	always_comb
	begin
		case (op)
		LDB, LDBU, LDBX, STB, STBX: szNext = byt;
		LDW, LDWU, STW:             szNext = wyde;
		default:                    szNext = octa;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			isLoad     <= 1'b0;
			isStore    <= 1'b0;
			ldz        <= 1'b0;
			isIndexed  <= 1'b0;
			memSz      <= byt;
			isJump     <= 1'b0;
			isCbranch  <= 1'b0;
			isMul      <= 1'b0;
			isDiv      <= 1'b0;
			multiCycle <= 1'b0;
		end
		else if (decEn)
		begin
			isLoad     <= ld;
			isStore    <= st;
			ldz        <= op inside {LDBU, LDWU};
			isIndexed  <= op inside {LDBX, LDOX, STBX, STOX};
			memSz      <= szNext;
			isJump     <= op inside {JMP, BRA};
			isCbranch  <= op inside {JEQ, JNE, JLT};
			isMul      <= mul;
			isDiv      <= div;
			// Every memory access goes through the load/store unit
			multiCycle <= mul || div || ld || st;
		end
	end

endmodule

`default_nettype wire

// File: thorDecodeTop.sv
// Thor decode stage top level
// One-cycle registered decode: control plus three datapath blocks

`timescale 1ns/1ps
`default_nettype none

module thorDecodeTop (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   irValid,
	input  thorDecodePkg::instrT  ir,
	output logic                  decoValid,
	output thorDecodePkg::regT    ra,
	output thorDecodePkg::regT    rb,
	output thorDecodePkg::regT    rc,
	output thorDecodePkg::regT    rt,
	output logic                  rfwr,
	output thorDecodePkg::valueT  imm,
	output thorDecodePkg::valueT  jmpTgt,
	output logic                  isLoad,
	output logic                  isStore,
	output logic                  ldz,
	output logic                  isIndexed,
	output thorDecodePkg::memSzT  memSz,
	output logic                  isJump,
	output logic                  isCbranch,
	output logic                  isMul,
	output logic                  isDiv,
	output logic                  multiCycle
);

	import thorDecodePkg::*;

	logic decEn;
	logic pfxValid;
	logic [pfxWidth-1:0] pfxExt;

	thorDecodeCtrl ctrl0 (
		.clk(clk), .rstN(rstN), .irValid(irValid), .ir(ir),
		.decEn(decEn), .pfxValid(pfxValid), .pfxExt(pfxExt), .decoValid(decoValid)
	);

	thorRegSelect regSel0 (
		.clk(clk), .rstN(rstN), .decEn(decEn), .ir(ir),
		.ra(ra), .rb(rb), .rc(rc), .rt(rt), .rfwr(rfwr)
	);

	thorConstGen constGen0 (
		.clk(clk), .rstN(rstN), .decEn(decEn), .ir(ir),
		.pfxValid(pfxValid), .pfxExt(pfxExt), .imm(imm), .jmpTgt(jmpTgt)
	);

	thorOpClass opClass0 (
		.clk(clk), .rstN(rstN), .decEn(decEn), .ir(ir),
		.isLoad(isLoad), .isStore(isStore), .ldz(ldz), .isIndexed(isIndexed),
		.memSz(memSz), .isJump(isJump), .isCbranch(isCbranch),
		.isMul(isMul), .isDiv(isDiv), .multiCycle(multiCycle)
	);

endmodule

`default_nettype wire

// File: thorDecode_assertions.sv
// Thor decode stage protocol checks
// Valid timing and mutually exclusive class flags at the top level

`timescale 1ns/1ps
`default_nettype none

module thorDecode_assertions (
	input wire clk,
	input wire rstN,
	input wire irValid,
	input wire decoValid,
	input wire isLoad,
	input wire isStore,
	input wire isCbranch
);

	// Output valid only follows an accepted instruction
	validFollowsInput: assert property (@(posedge clk) disable iff (!rstN)
		decoValid |-> $past(irValid))
		else $error("decoValid without irValid in the previous cycle");

	loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(isLoad && isStore))
		else $error("isLoad and isStore high together");

	branchNotMemory: assert property (@(posedge clk) disable iff (!rstN)
		isCbranch |-> !(isLoad || isStore))
		else $error("isCbranch together with a memory flag");

	quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !decoValid)
		else $error("decoValid high right after reset release");

endmodule

`default_nettype wire

// File: thorDecodeModel.svh
// Thor decode reference model
// Applies the decode rules to one instruction, merging a pending
// prefix into the immediate, and returns the expected record

`ifndef THOR_DECODE_MODEL_SVH
`define THOR_DECODE_MODEL_SVH

// Sign extension of the low width bits of v
function automatic valueT signExtend(input valueT v, input int width);
	valueT mask;
	mask = ~valueT'(0) << width;
	if (v[width-1])
		return v | mask;
	return v & ~mask;
endfunction

function automatic expT modelDecode(input instrT instr, input logic pfxV,
	input logic [pfxWidth-1:0] pfx);
	expT e;
	opcodeT op;
	funcT fn;
	logic isLd;
	logic isSt;
	logic isFlow;
	valueT plain;
	op = opcodeT'(instr[6:0]);
	fn = funcT'(instr[33:27]);
	isLd = op inside {LDB, LDBU, LDW, LDWU, LDO, LDBX, LDOX};
	isSt = op inside {STB, STW, STO, STBX, STOX};
	isFlow = op inside {JMP, BRA, JEQ, JNE, JLT};
	e = '0;

	// ==============================
	// Register fields
	// ==============================
	e.ra = instr[16:12];
	e.rb = instr[21:17];
	e.rc = isSt ? instr[11:7] : instr[26:22];
	if (isSt || op == NOP)
		e.rt = '0;
	else if (isFlow)
		e.rt = {3'b000, instr[8:7]};
	else
		e.rt = instr[11:7];
	if (isLd || op inside {R2, ADDI, ANDI, ORI, XORI, SLLI})
		e.rfwr = 1'b1;
	else if (isFlow)
		e.rfwr = |instr[8:7];

	// ==============================
	// Constants
	// ==============================
	case (op)
	ADDI:      plain = signExtend(valueT'(instr[29:17]), 13);
	ANDI:      plain = (~valueT'(0) << 13) | valueT'(instr[29:17]);
	ORI, XORI: plain = valueT'(instr[29:17]);
	SLLI:      plain = valueT'(instr[22:17]);
	LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO:
		plain = signExtend(valueT'(instr[39:17]), 23);
	default:   plain = '0;
	endcase
	if (pfxV)
		e.imm = (signExtend(valueT'(pfx), pfxWidth) << immLowWidth)
			| (plain & ((valueT'(1) << immLowWidth) - valueT'(1)));
	else
		e.imm = plain;
	if (op inside {JMP, BRA})
		e.jmpTgt = signExtend(valueT'(instr[39:12]), 28) << 1;
	else if (op inside {JEQ, JNE, JLT})
		e.jmpTgt = signExtend(valueT'(instr[39:27]), 13) << 1;

	// ==============================
	// Classification
	// ==============================
	e.isLoad = isLd;
	e.isStore = isSt;
	e.ldz = op inside {LDBU, LDWU};
	e.isIndexed = op inside {LDBX, LDOX, STBX, STOX};
	if (op inside {LDB, LDBU, LDBX, STB, STBX})
		e.memSz = byt;
	else if (op inside {LDW, LDWU, STW})
		e.memSz = wyde;
	else
		e.memSz = octa;
	e.isJump = op inside {JMP, BRA};
	e.isCbranch = op inside {JEQ, JNE, JLT};
	e.isMul = (op == R2) && (fn == MUL);
	e.isDiv = (op == R2) && (fn == DIV);
	e.multiCycle = e.isMul || e.isDiv || isLd || isSt;
	return e;
endfunction

`endif

// File: tbThorDecode.sv
// Thor decode stage testbench
// Random instruction streams with prefixes and idle gaps, checked
// against a reference model at every output valid pulse

`timescale 1ns/1ps
`default_nettype none

module tbThorDecode;

	import thorDecodePkg::*;

	typedef struct packed {
		regT ra;
		regT rb;
		regT rc;
		regT rt;
		logic rfwr;
		valueT imm;
		valueT jmpTgt;
		logic isLoad;
		logic isStore;
		logic ldz;
		logic isIndexed;
		memSzT memSz;
		logic isJump;
		logic isCbranch;
		logic isMul;
		logic isDiv;
		logic multiCycle;
		int cycle;
	} expT;

	`include "thorDecodeModel.svh"

	// Reset, six tests and a short drain after each
	localparam int stimCycles = 5 + 2 + 400 + 400 + 300 + 300 + 300 + 6 * 4;
	localparam int cycleLimit = 2 * stimCycles + 100;

	logic clk;
	logic rstN;
	logic irValid;
	instrT ir;
	logic decoValid;
	regT ra;
	regT rb;
	regT rc;
	regT rt;
	logic rfwr;
	valueT imm;
	valueT jmpTgt;
	logic isLoad;
	logic isStore;
	logic ldz;
	logic isIndexed;
	memSzT memSz;
	logic isJump;
	logic isCbranch;
	logic isMul;
	logic isDiv;
	logic multiCycle;

	expT expQ[$];
	expT lastRec = '0;
	logic mPfxValid;
	logic [pfxWidth-1:0] mPfx;
	int cycleCount = 0;
	int errCount = 0;
	int checkCount = 0;
	int testErrBase = 0;
	opcodeT allOps [24] = '{NOP, R2, ADDI, ANDI, ORI, XORI, SLLI,
		LDB, LDBU, LDW, LDWU, LDO, LDBX, LDOX, STB, STW, STO, STBX, STOX,
		JMP, BRA, JEQ, JNE, JLT};
	funcT allFuncs [7] = '{ADD, SUB, AND, OR, MUL, DIV, SLL};

	thorDecodeTop dut0 (.*);

	bind thorDecodeTop thorDecode_assertions asrt0 (
		.clk(clk), .rstN(rstN), .irValid(irValid), .decoValid(decoValid),
		.isLoad(isLoad), .isStore(isStore), .isCbranch(isCbranch)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run passed %0d cycles without finishing", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	// ==============================
	// Compare tasks
	// ==============================
	task automatic checkReg(input string what, input regT got, input regT exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkValue(input string what, input valueT got, input valueT exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkSize(input string what, input memSzT got, input memSzT exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compareAll(input expT e);
		checkReg("ra", ra, e.ra);
		checkReg("rb", rb, e.rb);
		checkReg("rc", rc, e.rc);
		checkReg("rt", rt, e.rt);
		checkFlag("rfwr", rfwr, e.rfwr);
		checkValue("imm", imm, e.imm);
		checkValue("jmpTgt", jmpTgt, e.jmpTgt);
		checkFlag("isLoad", isLoad, e.isLoad);
		checkFlag("isStore", isStore, e.isStore);
		checkFlag("ldz", ldz, e.ldz);
		checkFlag("isIndexed", isIndexed, e.isIndexed);
		checkSize("memSz", memSz, e.memSz);
		checkFlag("isJump", isJump, e.isJump);
		checkFlag("isCbranch", isCbranch, e.isCbranch);
		checkFlag("isMul", isMul, e.isMul);
		checkFlag("isDiv", isDiv, e.isDiv);
		checkFlag("multiCycle", multiCycle, e.multiCycle);
	endtask

	// Outputs are stable at the falling edge; between pulses they must hold
	always @(negedge clk)
	begin
		if (decoValid)
		begin
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("Unexpected decode output at %0t with nothing outstanding", $time);
			end
			else
			begin
				lastRec = expQ.pop_front();
				if (cycleCount != lastRec.cycle + 1)
				begin
					errCount++;
					$display("ERR %0t: decode latency %0d cycles, expected 1", $time,
						cycleCount - lastRec.cycle);
				end
				compareAll(lastRec);
			end
		end
		else
			compareAll(lastRec);
	end

	// ==============================
	// Stimulus
	// ==============================
	function automatic instrT randInstr(input int lo, input int hi);
		instrT instr;
		opcodeT op;
		int idx;
		idx = lo + int'($urandom % (hi - lo + 1));
		op = allOps[idx];
		instr = instrT'({$urandom(), $urandom()});
		instr[6:0] = op;
		idx = int'($urandom % 7);
		if (op == R2)
			instr[33:27] = allFuncs[idx];
		return instr;
	endfunction

	function automatic instrT exiInstr();
		instrT instr;
		instr = instrT'({$urandom(), $urandom()});
		instr[6:0] = EXI;
		return instr;
	endfunction

	// About one in five is a prefix
	function automatic instrT mixedInstr();
		if ($urandom % 5 == 0)
			return exiInstr();
		return randInstr(0, 23);
	endfunction

	task automatic present(input logic valid, input instrT instr);
		expT e;
		@(posedge clk);
		#1;
		irValid = valid;
		ir = instr;
		if (valid)
		begin
			if (instr[6:0] == EXI)
			begin
				mPfxValid = 1'b1;
				mPfx = instr[39:7];
			end
			else
			begin
				e = modelDecode(instr, mPfxValid, mPfx);
				e.cycle = cycleCount;
				expQ.push_back(e);
				mPfxValid = 1'b0;
			end
		end
	endtask

	task automatic finishTest(input string name);
		int drain;
		drain = 0;
		@(posedge clk);
		#1;
		irValid = 1'b0;
		// One cycle of latency, so a few cycles drain every outstanding decode
		while (expQ.size() != 0 && drain < 4)
		begin
			@(negedge clk);
			drain++;
		end
		repeat (2) @(negedge clk);
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("%0d decoded instructions never produced an output", expQ.size());
			expQ.delete();
		end
		$display("%-24s %0d errors", name, errCount - testErrBase);
		testErrBase = errCount;
	endtask

	initial
	begin
		void'($urandom(32'h64762472));
		rstN = 1'b0;
		irValid = 1'b0;
		ir = '0;
		mPfxValid = 1'b0;
		mPfx = '0;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
		finishTest("reset state");

		repeat (400) present(1'b1, randInstr(1, 23));
		finishTest("register selection");

		repeat (400) present(1'b1, randInstr(2, 23));
		finishTest("immediates and targets");

		repeat (300) present(1'b1, mixedInstr());
		finishTest("prefix extension");

		repeat (300) present(1'b1, randInstr(0, 23));
		finishTest("classification");

		// Idle cycles still carry random instruction bits
		repeat (300) present(($urandom % 3) != 0, mixedInstr());
		finishTest("gaps in the stream");

		$display("Summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
thorDecodePkg.sv
thorDecodeCtrl.sv
thorRegSelect.sv
thorConstGen.sv
thorOpClass.sv
thorDecodeTop.sv
thorDecode_assertions.sv
tbThorDecode.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
verilator --binary --timing --assert --top-module tbThorDecode -f src.f \
	-o simThorDecode > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simThorDecode > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Failure reported in sim.log"; exit 1; }
grep -q "Test OK" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0
